//--- src/cpu_pkg.sv
package cpu_pkg;

    localparam int data_w    = 8;
    localparam int reg_cnt   = 16;
    localparam int reg_idx_w = 4;

    // Opcodes 8 to 15 are not decoded and run as no-ops.
    localparam logic [3:0] op_jmp  = 4'd0;
    localparam logic [3:0] op_lod  = 4'd1;
    localparam logic [3:0] op_str  = 4'd2;
    localparam logic [3:0] op_add  = 4'd3;
    localparam logic [3:0] op_addi = 4'd4;
    localparam logic [3:0] op_lodi = 4'd5;
    localparam logic [3:0] op_nand = 4'd6;
    localparam logic [3:0] op_jeqz = 4'd7;

    // Three register fields after the opcode.
    typedef struct packed {
        logic [3:0]           op;
        logic [reg_idx_w-1:0] rd;
        logic [reg_idx_w-1:0] rs;
        logic [reg_idx_w-1:0] rt;
    } inst_reg_t;

    // Destination register and an 8-bit constant, used by JMP and LODI.
    typedef struct packed {
        logic [3:0]           op;
        logic [reg_idx_w-1:0] rd;
        logic [data_w-1:0]    imm;
    } inst_imm_t;

    // The high byte sits at the program counter, the low byte one above it.
    typedef union packed {
        inst_reg_t r;
        inst_imm_t i;
    } inst_u;

endpackage

//--- src/fetch.sv
`timescale 1ns/1ps

module fetch (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        en,
    input  logic [cpu_pkg::data_w-1:0]  pc,
    input  logic [cpu_pkg::data_w-1:0]  data_in,
    input  logic                        mem_ready,
    output logic                        mem_req,
    output logic [cpu_pkg::data_w-1:0]  addr,
    output cpu_pkg::inst_u              inst,
    output logic                        ready
);

    logic second; // High byte is in, the low byte is being read.

    // Keep asking for the bus until both bytes have arrived.
    assign mem_req = en && !ready;
    assign addr    = second ? pc + 8'd1 : pc;

    always_ff @(posedge clk) begin
        if (rst || !en) begin
            // A read still in flight returns while en is low and is dropped.
            second <= 1'b0;
            ready  <= 1'b0;
        end else if (!ready && mem_ready) begin
            if (!second) begin
                second <= 1'b1;
            end else begin
                ready <= 1'b1;
            end
        end
    end

    // Each returning byte lands in its half of the instruction word.
    always_ff @(posedge clk) begin
        if (en && !ready && mem_ready) begin
            if (!second) begin
                {inst.i.op, inst.i.rd} <= data_in;
            end else begin
                inst.i.imm <= data_in;
            end
        end
    end

endmodule

//--- src/decode.sv
`timescale 1ns/1ps

module decode (
    input  logic                          clk,
    input  logic                          en,
    input  cpu_pkg::inst_u                inst,
    output logic [3:0]                    op,
    output logic [cpu_pkg::reg_idx_w-1:0] rd,
    output logic [cpu_pkg::reg_idx_w-1:0] rs,
    output logic [cpu_pkg::reg_idx_w-1:0] rt,
    output logic [cpu_pkg::data_w-1:0]    imm,
    output logic                          ready
);

    logic wide_imm;

    // JMP and LODI carry a full byte, ADDI only the 4-bit rt field.
    assign wide_imm = inst.r.op == cpu_pkg::op_jmp || inst.r.op == cpu_pkg::op_lodi;

    always_ff @(posedge clk) begin
        ready <= en; // Fields are valid one cycle after en.
        if (en && !ready) begin
            op <= inst.r.op;
            rd <= inst.r.rd;
            rs <= inst.r.rs;
            rt <= inst.r.rt;
            if (wide_imm) begin
                imm <= inst.i.imm;
            end else begin
                imm <= {4'b0000, inst.r.rt};
            end
        end
    end

endmodule

//--- src/exec.sv
`timescale 1ns/1ps

module exec (
    input  logic                        clk,
    input  logic                        en,
    input  logic [3:0]                  op,
    input  logic [cpu_pkg::data_w-1:0]  a,
    input  logic [cpu_pkg::data_w-1:0]  b,
    input  logic [cpu_pkg::data_w-1:0]  imm,
    input  logic                        mem_ready,
    input  logic [cpu_pkg::data_w-1:0]  mem_data_in,
    output logic [cpu_pkg::data_w-1:0]  val,
    output logic [cpu_pkg::data_w-1:0]  mem_addr,
    output logic [cpu_pkg::data_w-1:0]  mem_data_out,
    output logic                        mem_req,
    output logic                        mem_we,
    output logic [cpu_pkg::data_w-1:0]  pc_out,
    output logic                        flush,
    output logic                        ready
);

    logic started;
    logic is_mem;

    assign is_mem = op == cpu_pkg::op_lod || op == cpu_pkg::op_str;

    // The bus request goes out in the cycle after en, never in the first one.
    assign mem_req      = en && started && !ready && is_mem;
    assign mem_we       = op == cpu_pkg::op_str;
    assign mem_addr     = (op == cpu_pkg::op_lod) ? a + b : b; // STR stores a at b.
    assign mem_data_out = a;

    always_ff @(posedge clk) begin
        if (!en) begin
            started <= 1'b0;
            ready   <= 1'b0;
            flush   <= 1'b0;
        end else if (!started) begin
            started <= 1'b1;
            ready   <= !is_mem;
            flush   <= 1'b0;
            case (op)
                cpu_pkg::op_add: begin
                    val <= a + b;
                end
                cpu_pkg::op_addi: begin
                    val <= a + imm;
                end
                cpu_pkg::op_nand: begin
                    val <= ~(a & b);
                end
                cpu_pkg::op_lodi: begin
                    val <= imm;
                end
                cpu_pkg::op_jmp: begin
                    pc_out <= imm;
                    flush  <= 1'b1;
                end
                cpu_pkg::op_jeqz: begin
                    pc_out <= b;
                    flush  <= (a == '0); // Taken only for a zero register.
                end
                default: begin
                end
            endcase
        end else if (!ready && mem_ready) begin
            // Read data is on the bus in the same cycle as the ready strobe.
            if (op == cpu_pkg::op_lod) begin
                val <= mem_data_in;
            end
            ready <= 1'b1;
        end
    end

endmodule

//--- src/writeback.sv
`timescale 1ns/1ps

module writeback (
    input  logic                                               clk,
    input  logic                                               rst,
    input  logic                                               en,
    input  logic [3:0]                                         op,
    input  logic [cpu_pkg::reg_idx_w-1:0]                      rd,
    input  logic [cpu_pkg::data_w-1:0]                         val,
    output logic [cpu_pkg::reg_cnt-1:0][cpu_pkg::data_w-1:0]   regs,
    output logic                                               ready
);

    logic writes_rd;

    // Only these opcodes produce a register result.
    assign writes_rd = op == cpu_pkg::op_add  ||
                       op == cpu_pkg::op_addi ||
                       op == cpu_pkg::op_nand ||
                       op == cpu_pkg::op_lod  ||
                       op == cpu_pkg::op_lodi;

    always_ff @(posedge clk) begin
        if (rst) begin
            regs  <= '0;
            ready <= 1'b0;
        end else begin
            ready <= en;
            if (en && !ready && writes_rd) begin
                regs[rd] <= val; // Visible to the top when ready rises.
            end
        end
    end

endmodule

//--- src/mem_if.sv
`timescale 1ns/1ps

module mem_if #(
    parameter int CLIENT_CNT = 2
) (
    input  logic                                   clk,
    input  logic                                   rst,
    input  logic [CLIENT_CNT-1:0]                  requests,
    input  logic [CLIENT_CNT-1:0]                  wes,
    input  logic [CLIENT_CNT*cpu_pkg::data_w-1:0]  addrs,
    input  logic [CLIENT_CNT*cpu_pkg::data_w-1:0]  data_outs,
    output logic [CLIENT_CNT-1:0]                  readies,
    output logic [cpu_pkg::data_w-1:0]             addr,
    output logic [cpu_pkg::data_w-1:0]             data_out,
    output logic                                   we
);

    logic [CLIENT_CNT-1:0] grant; // One-hot grant of the client served in the last cycle.
    logic [CLIENT_CNT-1:0] pick;

    // No new grant in a ready cycle, so each access takes two cycles.
    always_comb begin
        pick = '0;
        if (grant == '0) begin
            for (int i = 0; i < CLIENT_CNT; i++) begin
                if (requests[i]) begin
                    pick    = '0;
                    pick[i] = 1'b1; // Later clients override earlier ones.
                end
            end
        end
    end

    always_comb begin
        addr     = '0;
        data_out = '0;
        we       = 1'b0;
        for (int i = 0; i < CLIENT_CNT; i++) begin
            if (pick[i]) begin
                addr     = addrs[i*cpu_pkg::data_w +: cpu_pkg::data_w];
                data_out = data_outs[i*cpu_pkg::data_w +: cpu_pkg::data_w];
                we       = wes[i];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            grant <= '0;
        end else begin
            grant <= pick;
        end
    end

    assign readies = grant;

endmodule

//--- src/eightbit.sv
`timescale 1ns/1ps

module eightbit (
    input  logic                        clk,
    input  logic                        rst,
    input  logic [cpu_pkg::data_w-1:0]  data_in,
    output logic [cpu_pkg::data_w-1:0]  data_out,
    output logic [cpu_pkg::data_w-1:0]  addr,
    output logic                        we
);

    logic [cpu_pkg::data_w-1:0] pc;
    logic [cpu_pkg::reg_cnt-1:0][cpu_pkg::data_w-1:0] regs;

    logic                       fetch_en;
    logic                       fetch_ready;
    logic                       fetch_mem_req;
    logic                       fetch_mem_ready;
    logic [cpu_pkg::data_w-1:0] fetch_addr;
    cpu_pkg::inst_u             fetch_inst;

    logic                          decode_en;
    logic                          decode_ready;
    cpu_pkg::inst_u                decode_inst;
    logic [3:0]                    decode_op;
    logic [cpu_pkg::reg_idx_w-1:0] decode_rd;
    logic [cpu_pkg::reg_idx_w-1:0] decode_rs;
    logic [cpu_pkg::reg_idx_w-1:0] decode_rt;
    logic [cpu_pkg::data_w-1:0]    decode_imm;

    logic                          exec_en;
    logic                          exec_ready;
    logic [3:0]                    exec_op;
    logic [cpu_pkg::reg_idx_w-1:0] exec_rd;
    logic [cpu_pkg::data_w-1:0]    exec_a;
    logic [cpu_pkg::data_w-1:0]    exec_b;
    logic [cpu_pkg::data_w-1:0]    exec_imm;
    logic [cpu_pkg::data_w-1:0]    exec_val;
    logic [cpu_pkg::data_w-1:0]    exec_pc_out;
    logic                          exec_flush;
    logic [cpu_pkg::data_w-1:0]    exec_mem_addr;
    logic [cpu_pkg::data_w-1:0]    exec_mem_data_out;
    logic                          exec_mem_req;
    logic                          exec_mem_we;
    logic                          exec_mem_ready;

    logic                          wb_en;
    logic                          wb_ready;
    logic [3:0]                    wb_op;
    logic [cpu_pkg::reg_idx_w-1:0] wb_rd;
    logic [cpu_pkg::data_w-1:0]    wb_val;

    logic                          uses_rd;
    logic [cpu_pkg::data_w-1:0]    sel_a;
    logic [cpu_pkg::data_w-1:0]    sel_b;

    // Stores and branches read rd as their first operand.
    assign uses_rd = decode_op == cpu_pkg::op_str ||
                     decode_op == cpu_pkg::op_jmp ||
                     decode_op == cpu_pkg::op_jeqz;
    assign sel_a = uses_rd ? regs[decode_rd] : regs[decode_rs];
    assign sel_b = uses_rd ? regs[decode_rs] : regs[decode_rt];

    fetch u_fetch (
        .clk(clk), .rst(rst), .en(fetch_en), .pc(pc), .data_in(data_in),
        .mem_ready(fetch_mem_ready), .mem_req(fetch_mem_req), .addr(fetch_addr),
        .inst(fetch_inst), .ready(fetch_ready)
    );

    decode u_decode (
        .clk(clk), .en(decode_en), .inst(decode_inst), .op(decode_op),
        .rd(decode_rd), .rs(decode_rs), .rt(decode_rt), .imm(decode_imm),
        .ready(decode_ready)
    );

    exec u_exec (
        .clk(clk), .en(exec_en), .op(exec_op), .a(exec_a), .b(exec_b), .imm(exec_imm),
        .mem_ready(exec_mem_ready), .mem_data_in(data_in), .val(exec_val),
        .mem_addr(exec_mem_addr), .mem_data_out(exec_mem_data_out),
        .mem_req(exec_mem_req), .mem_we(exec_mem_we), .pc_out(exec_pc_out),
        .flush(exec_flush), .ready(exec_ready)
    );

    writeback u_writeback (
        .clk(clk), .rst(rst), .en(wb_en), .op(wb_op), .rd(wb_rd), .val(wb_val),
        .regs(regs), .ready(wb_ready)
    );

    // Exec is client 1 and wins over instruction fetch.
    mem_if #(.CLIENT_CNT(2)) u_mem_if (
        .clk(clk), .rst(rst),
        .requests({exec_mem_req, fetch_mem_req}),
        .wes({exec_mem_we, 1'b0}),
        .addrs({exec_mem_addr, fetch_addr}),
        .data_outs({exec_mem_data_out, 8'h00}),
        .readies({exec_mem_ready, fetch_mem_ready}),
        .addr(addr), .data_out(data_out), .we(we)
    );

    always_ff @(posedge clk) begin
        if (rst) begin
            pc        <= '0;
            fetch_en  <= 1'b0;
            decode_en <= 1'b0;
            exec_en   <= 1'b0;
            wb_en     <= 1'b0;
        end else begin
            if (!fetch_en) begin
                fetch_en <= 1'b1; // One low cycle is enough to idle fetch.
            end
            if (fetch_en && fetch_ready && !decode_en) begin
                decode_inst <= fetch_inst;
                pc          <= pc + 8'd2;
                fetch_en    <= 1'b0;
                decode_en   <= 1'b1;
            end
            // Waiting for writeback keeps operand reads behind the last commit.
            if (decode_en && decode_ready && !exec_en && !wb_en) begin
                exec_op   <= decode_op;
                exec_rd   <= decode_rd;
                exec_a    <= sel_a;
                exec_b    <= sel_b;
                exec_imm  <= decode_imm;
                exec_en   <= 1'b1;
                decode_en <= 1'b0;
            end
            if (wb_en && wb_ready) begin
                wb_en <= 1'b0;
            end
            if (exec_en && exec_ready) begin
                exec_en <= 1'b0;
                if (exec_flush) begin
                    // Comes last so it overrides a capture in the same cycle.
                    pc        <= exec_pc_out;
                    fetch_en  <= 1'b0;
                    decode_en <= 1'b0;
                end else begin
                    wb_op  <= exec_op;
                    wb_rd  <= exec_rd;
                    wb_val <= exec_val;
                    wb_en  <= 1'b1;
                end
            end
        end
    end

endmodule

//--- bench/tb_memory.sv
`timescale 1ns/1ps

module tb_memory (
    input  logic       clk,
    input  logic       load,
    input  logic [7:0] image [256],
    input  logic [7:0] addr,
    input  logic [7:0] wr_data,
    input  logic       we,
    output logic [7:0] rd_data
);

    logic [7:0]  mem [256];
    logic [7:0]  q = 8'h00;
    logic [15:0] log_q [$]; // Address in the high byte, data in the low byte.

    assign rd_data = q;

    always @(posedge clk) begin
        q <= mem[addr]; // A write to the same address still returns the old byte.
        if (load) begin
            // A new program image also starts a fresh write log.
            mem <= image;
            log_q.delete();
        end else if (we) begin
            mem[addr] <= wr_data;
            log_q.push_back({addr, wr_data});
        end
    end

endmodule

//--- bench/tb_eightbit.sv
`timescale 1ns/1ps

module tb_eightbit;

    localparam logic [3:0] op_jmp  = 4'd0;
    localparam logic [3:0] op_lod  = 4'd1;
    localparam logic [3:0] op_str  = 4'd2;
    localparam logic [3:0] op_add  = 4'd3;
    localparam logic [3:0] op_addi = 4'd4;
    localparam logic [3:0] op_lodi = 4'd5;
    localparam logic [3:0] op_nand = 4'd6;
    localparam logic [3:0] op_jeqz = 4'd7;
    localparam int mem_size        = 256;
    localparam int run_bound       = 280; // Cycles allowed for one program.
    localparam int run_cnt         = 7;
    localparam int watchdog_cycles = 2 * run_cnt * (run_bound + 8);

    logic       clk;
    logic       rst;
    logic       load;
    logic       we;
    logic [7:0] addr;
    logic [7:0] data_out;
    logic [7:0] data_in;
    logic [7:0] image [256];
    logic [7:0] asm_pc;
    logic [7:0] exp_addr [$];
    logic [7:0] exp_data [$];
    int         seed;

    eightbit DUT (
        .clk(clk), .rst(rst), .data_in(data_in), .data_out(data_out), .addr(addr), .we(we)
    );

    tb_memory mem_model (
        .clk(clk), .load(load), .image(image), .addr(addr), .wr_data(data_out), .we(we),
        .rd_data(data_in)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    initial begin
        repeat (watchdog_cycles) @(posedge clk);
        $display("Watchdog expired after %0d cycles.", watchdog_cycles);
        $display("STATUS: FAIL");
        $fatal(1, "simulation timed out");
    end

    task automatic check(input string name, input logic [7:0] got, input logic [7:0] want);
        if (got !== want) begin
            $display("[FAIL] %s got %h expected %h", name, got, want);
            $display("STATUS: FAIL");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    function automatic logic [7:0] rand_byte();
        int r;
        r = $random(seed);
        return r[7:0];
    endfunction

    task automatic new_program();
        logic [7:0] a;
        a = 8'h00;
        repeat (mem_size) begin
            image[a] = {a[3:0], a[7:4]} ^ 8'h3c;
            a = a + 8'd1;
        end
        asm_pc = 8'h00;
        exp_addr.delete();
        exp_data.delete();
    endtask

    task automatic emit(input logic [3:0] op, input logic [3:0] rd, input logic [3:0] rs,
                        input logic [3:0] rt);
        image[asm_pc]        = {op, rd}; // High byte first.
        image[asm_pc + 8'd1] = {rs, rt};
        asm_pc = asm_pc + 8'd2;
    endtask

    task automatic load_const(input logic [3:0] rd, input logic [7:0] value);
        emit(op_lodi, rd, value[7:4], value[3:0]);
    endtask

    task automatic jump_to(input logic [7:0] target);
        emit(op_jmp, 4'd0, target[7:4], target[3:0]);
    endtask

    task automatic expect_write(input logic [7:0] a, input logic [7:0] d);
        exp_addr.push_back(a);
        exp_data.push_back(d);
    endtask

    // r7 holds the address, so tests keep their data in r1 to r6.
    task automatic store_to(input logic [3:0] rd, input logic [7:0] a, input logic [7:0] d);
        load_const(4'd7, a);
        emit(op_str, rd, 4'd7, 4'd0);
        expect_write(a, d);
    endtask

    // Marker store to 0xFF, then the program spins on a jump to itself.
    task automatic end_program();
        load_const(4'd15, 8'hff);
        emit(op_str, 4'd15, 4'd15, 4'd0);
        expect_write(8'hff, 8'hff);
        jump_to(asm_pc);
    endtask

    task automatic run_program();
        int          cycles;
        logic [15:0] entry;
        @(negedge clk);
        rst  = 1'b1;
        load = 1'b1;
        repeat (3) begin
            @(negedge clk);
            load = 1'b0;
            check("we", 8'(we), 8'h00);
        end
        rst = 1'b0;
        @(negedge clk);
        check("addr", addr, 8'h00); // First fetch reads address 0.
        check("we", 8'(we), 8'h00);
        repeat (2) @(negedge clk);
        check("addr", addr, 8'h01); // The low byte is read two cycles later.
        cycles = 0;
        while (!(we && addr == 8'hff)) begin
            if (cycles == run_bound) begin
                $display("No marker store within %0d cycles.", run_bound);
                $display("STATUS: FAIL");
                $fatal(1, "program did not finish");
            end else begin
                @(negedge clk);
                cycles++;
            end
        end
        @(negedge clk);
        check("write count", 8'(mem_model.log_q.size()), 8'(exp_addr.size()));
        for (int k = 0; k < exp_addr.size(); k++) begin
            entry = mem_model.log_q[k];
            check($sformatf("write %0d addr", k), entry[15:8], exp_addr[k]);
            check($sformatf("write %0d data", k), entry[7:0], exp_data[k]);
        end
    endtask

    task automatic test_lodi_str();
        new_program();
        load_const(4'd1, 8'h3c);
        load_const(4'd2, 8'ha5);
        load_const(4'd3, 8'h00);
        load_const(4'd4, 8'hfe);
        store_to(4'd1, 8'h50, 8'h3c);
        store_to(4'd2, 8'h61, 8'ha5);
        store_to(4'd3, 8'h72, 8'h00);
        store_to(4'd4, 8'h83, 8'hfe);
        end_program();
        run_program();
    endtask

    task automatic test_arith();
        logic [7:0] x, y, k, s, t, u, w;
        x = rand_byte();
        y = rand_byte();
        k = rand_byte() & 8'h0f;
        s = x + y;
        t = s + k;
        u = ~(t & x);
        w = u + u;
        new_program();
        load_const(4'd1, x);
        load_const(4'd2, y);
        emit(op_add, 4'd3, 4'd1, 4'd2); // Each result feeds the next instruction.
        emit(op_addi, 4'd4, 4'd3, k[3:0]);
        emit(op_nand, 4'd5, 4'd4, 4'd1);
        emit(op_add, 4'd6, 4'd5, 4'd5);
        store_to(4'd3, 8'h40, s);
        store_to(4'd4, 8'h41, t);
        store_to(4'd5, 8'h42, u);
        store_to(4'd6, 8'h43, w);
        end_program();
        run_program();
    endtask

    task automatic test_lod();
        logic [7:0] off, value;
        off   = rand_byte() & 8'h0f;
        value = rand_byte();
        new_program();
        image[8'h80 + off] = value;
        load_const(4'd1, 8'h80);
        load_const(4'd2, off);
        emit(op_lod, 4'd3, 4'd1, 4'd2);
        emit(op_addi, 4'd3, 4'd3, 4'd1);
        store_to(4'd3, 8'h30, value + 8'd1);
        end_program();
        run_program();
    endtask

    task automatic test_jmp_flush();
        new_program();
        load_const(4'd1, 8'h5a);
        load_const(4'd2, 8'hee);
        jump_to(8'h40);
        emit(op_str, 4'd1, 4'd2, 4'd0); // Stores to 0xEE must be flushed.
        emit(op_str, 4'd1, 4'd2, 4'd0);
        asm_pc = 8'h40;
        store_to(4'd1, 8'h30, 8'h5a);
        end_program();
        run_program();
    endtask

    task automatic jeqz_case(input logic [7:0] cond);
        new_program();
        load_const(4'd1, cond);
        load_const(4'd2, 8'h40);
        load_const(4'd3, 8'h77);
        emit(op_jeqz, 4'd1, 4'd2, 4'd0);
        store_to(4'd3, 8'h20, 8'h77);
        end_program();
        asm_pc = 8'h40;
        store_to(4'd3, 8'h21, 8'h77);
        end_program();
        exp_addr.delete(); // Only one of the two paths runs.
        exp_data.delete();
        if (cond == 8'h00) begin
            expect_write(8'h21, 8'h77);
        end else begin
            expect_write(8'h20, 8'h77);
        end
        expect_write(8'hff, 8'hff);
        run_program();
    endtask

    task automatic test_jeqz();
        jeqz_case(8'h00);
        jeqz_case(rand_byte() | 8'h01);
    endtask

    task automatic test_noop();
        logic [3:0] op;
        logic [7:0] v;
        v = rand_byte();
        new_program();
        load_const(4'd1, v);
        load_const(4'd2, 8'h1e);
        op = 4'd8;
        repeat (8) begin
            emit(op, 4'd1, 4'd2, 4'd1);
            op = op + 4'd1;
        end
        store_to(4'd1, 8'h60, v);
        store_to(4'd2, 8'h61, 8'h1e);
        end_program();
        run_program();
    endtask

    initial begin
        rst    = 1'b1;
        load   = 1'b0;
        seed   = 32'hff1e;
        asm_pc = 8'h00;
        test_lodi_str();
        test_arith();
        test_lod();
        test_jmp_flush();
        test_jeqz();
        test_noop();
        $display("STATUS: PASS");
        $finish;
    end

endmodule

//--- list.f
src/cpu_pkg.sv
src/fetch.sv
src/decode.sv
src/exec.sv
src/writeback.sv
src/mem_if.sv
src/eightbit.sv
bench/tb_memory.sv
bench/tb_eightbit.sv

//--- Makefile
LOG = sim.log

.PHONY: help test clean

help:
	@echo "make test   build tb_eightbit with Verilator, run it and check $(LOG)"
	@echo "make clean  remove obj_dir and $(LOG)"
	@echo "make help   show this list"

test:
	verilator --binary --timing --timescale 1ns/1ps --top-module tb_eightbit -f list.f
	-./obj_dir/Vtb_eightbit > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "STATUS: FAIL" $(LOG); then echo "Simulation failed."; exit 1; fi
	@grep -q "STATUS: PASS" $(LOG) || (echo "No pass line in $(LOG)."; exit 1)

clean:
	rm -rf obj_dir $(LOG)
